//--- Makefile
# Verilator build of the hazard control testbench

TOP := hazard_tb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -Mdir $(OBJ)
	@out=$$(./$(OBJ)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ)

//--- filelist.f
+incdir+verilog
verilog/hazard_pkg.sv
verilog/hazard_fifo.sv
verilog/instr_field_decoder.sv
verilog/hazard_detection_unit.sv
verilog/writeback_steering.sv
verilog/hazard_top.sv
sim/hazard_tb.sv

//--- sim/hazard_tb.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module hazard_tb;
  localparam int PERIOD = 4;
  localparam int FILL_LEN = 8;
  localparam logic [3:0] ALU = hazard_pkg::OPC_ALU;
  localparam logic [3:0] LOAD = hazard_pkg::OPC_LOAD;
  localparam logic [3:0] STORE = hazard_pkg::OPC_STORE;
  localparam logic [3:0] VALU = hazard_pkg::OPC_VALU;
  localparam logic [3:0] VRED = hazard_pkg::OPC_VREDUCE;
  localparam int WB_S = int'(hazard_pkg::WB_SCALAR);
  localparam int WB_V = int'(hazard_pkg::WB_VECTOR);
  localparam int WB_B = int'(hazard_pkg::WB_BUFFERED);

  // one row is one cycle of stimulus with the outputs expected in that same cycle
  typedef struct packed {
    logic [31:0] instr;
    logic valid;
    logic mstall;
    logic sd;
    logic se;
    logic [1:0] e2e;
    logic [1:0] m2e;
    logic [1:0] m2m;
    logic rfe;
    logic [4:0] rfa;
    logic [1:0] rfs;
    logic vfe;
    logic [4:0] vfa;
  } row_t;

  logic clk = 1'b0;
  logic rst;
  logic [31:0] instr;
  logic instr_valid;
  logic mem_stall_in;
  logic stall_fetch;
  logic stall_decode;
  logic stall_execute;
  logic stall_mem;
  logic [1:0] ex_to_ex;
  logic [1:0] mem_to_ex;
  logic [1:0] mem_to_mem;
  logic rf_wr_en;
  logic [`HAZ_REG_BITS-1:0] rf_wr_addr;
  hazard_pkg::wb_src_e rf_wr_src;
  logic vrf_wr_en;
  logic [`HAZ_REG_BITS-1:0] vrf_wr_addr;
  hazard_pkg::wb_src_e vrf_wr_src;

  row_t rows [$];
  logic [31:0] lfsr_state;
  logic table_ready = 1'b0;
  int checks = 0;
  int mismatches = 0;

  hazard_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .instr         (instr),
    .instr_valid   (instr_valid),
    .mem_stall_in  (mem_stall_in),
    .stall_fetch   (stall_fetch),
    .stall_decode  (stall_decode),
    .stall_execute (stall_execute),
    .stall_mem     (stall_mem),
    .ex_to_ex      (ex_to_ex),
    .mem_to_ex     (mem_to_ex),
    .mem_to_mem    (mem_to_mem),
    .rf_wr_en      (rf_wr_en),
    .rf_wr_addr    (rf_wr_addr),
    .rf_wr_src     (rf_wr_src),
    .vrf_wr_en     (vrf_wr_en),
    .vrf_wr_addr   (vrf_wr_addr),
    .vrf_wr_src    (vrf_wr_src)
  );

  always #(PERIOD / 2) clk = ~clk;

  // instruction word with opcode in 31..28, rd in 27..23, rs1 in 22..18 and rs2 in 17..13
  function automatic logic [31:0] enc(input logic [3:0] opc, input int rd, input int rs1,
                                      input int rs2);
    return {opc, rd[4:0], rs1[4:0], rs2[4:0], 13'd0};
  endfunction

  // galois LFSR stepped once per random bit
  function logic next_bit();
    next_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (next_bit) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
  endfunction

  // filler registers live in the upper half of the register file
  function int filler_reg();
    int r;
    r = 16;
    for (int b = 0; b < 4; b++) begin
      r = r | (int'(next_bit()) << b);
    end
    return r;
  endfunction

  task automatic row(input logic [31:0] ins, input int v, input int ms, input int sd,
                     input int se, input int e2e, input int m2e, input int m2m,
                     input int rfe, input int rfa, input int rfs, input int vfe,
                     input int vfa);
    row_t r;
    r.instr = ins;
    r.valid = v[0];
    r.mstall = ms[0];
    r.sd = sd[0];
    r.se = se[0];
    r.e2e = e2e[1:0];
    r.m2e = m2e[1:0];
    r.m2m = m2m[1:0];
    r.rfe = rfe[0];
    r.rfa = rfa[4:0];
    r.rfs = rfs[1:0];
    r.vfe = vfe[0];
    r.vfa = vfa[4:0];
    rows.push_back(r);
  endtask

  // idle slots that expect nothing at all
  task automatic nops(input int n);
    for (int i = 0; i < n; i++) begin
      row(32'd0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    end
  endtask

  // a run of ALU fillers and two slots to drain them
  // each filler writes its rd two slots after it is issued and forwards to its successors
  task automatic add_fillers();
    int rd [FILL_LEN];
    int s1 [FILL_LEN];
    int s2 [FILL_LEN];
    int e2e;
    int m2e;
    for (int j = 0; j < FILL_LEN; j++) begin
      rd[j] = filler_reg();
      s1[j] = filler_reg();
      s2[j] = filler_reg();
    end
    for (int j = 0; j < FILL_LEN + 2; j++) begin
      e2e = 0;
      m2e = 0;
      if (j >= 1 && j < FILL_LEN) begin
        e2e = (int'(s2[j] == rd[j-1]) << 1) | int'(s1[j] == rd[j-1]);
      end
      if (j >= 2 && j < FILL_LEN) begin
        m2e = ((int'(s2[j] == rd[j-2]) << 1) | int'(s1[j] == rd[j-2])) & ~e2e;
      end
      if (j < FILL_LEN) begin
        row(enc(ALU, rd[j], s1[j], s2[j]), 1, 0, 0, 0, e2e, m2e, 0,
            int'(j >= 2), (j >= 2) ? rd[j-2] : 0, WB_S, 0, 0);
      end else begin
        row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, rd[j-2], WB_S, 0, 0);
      end
    end
  endtask

  task automatic build_table();
    // first slot after reset shows the idle state
    nops(1);
    add_fillers();
    // scalar forwarding from execute, from mem, and load data into a store
    row(enc(ALU, 1, 2, 3), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(ALU, 4, 1, 5), 1, 0, 0, 0, 2'b01, 0, 0, 0, 0, 0, 0, 0);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 1, WB_S, 0, 0);
    row(enc(ALU, 6, 4, 7), 1, 0, 0, 0, 0, 2'b01, 0, 1, 4, WB_S, 0, 0);
    row(enc(LOAD, 8, 9, 0), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(STORE, 0, 10, 8), 1, 0, 0, 0, 0, 0, 2'b10, 1, 6, WB_S, 0, 0);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 8, WB_S, 0, 0);
    nops(2);
    // load-use costs one decode bubble and then forwards from mem
    row(enc(LOAD, 11, 12, 0), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(ALU, 13, 11, 14), 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(ALU, 13, 11, 14), 1, 0, 0, 0, 0, 2'b01, 0, 1, 11, WB_S, 0, 0);
    nops(1);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 13, WB_S, 0, 0);
    nops(1);
    add_fillers();
    // the reader of v2 waits until v2 has left the vector pipeline
    row(enc(VALU, 2, 3, 4), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    for (int k = 0; k < `HAZ_VECTOR_DEPTH; k++) begin
      row(enc(VALU, 5, 2, 6), 1, 0, 1, 0, 0, 0, 0, 0, 0, 0,
          int'(k == `HAZ_VECTOR_DEPTH - 1), 2);
    end
    row(enc(VALU, 5, 2, 6), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    nops(`HAZ_VECTOR_DEPTH - 1);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 5);
    nops(1);
    add_fillers();
    // memory back-pressure freezes the scalar writes for two cycles
    row(enc(ALU, 9, 10, 11), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(ALU, 12, 14, 15), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(32'd0, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    row(32'd0, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 9, WB_S, 0, 0);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 12, WB_S, 0, 0);
    nops(1);
    // the reduction is issued right behind the ALU, and a long memory stall
    // lets it arrive at writeback together with the older ALU result
    row(enc(ALU, 6, 1, 2), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    row(enc(VRED, 5, 1, 0), 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    for (int k = 0; k < `HAZ_VECTOR_DEPTH - 1; k++) begin
      row(32'd0, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    end
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 6, WB_S, 0, 0);
    row(32'd0, 0, 0, 0, 0, 0, 0, 0, 1, 5, WB_B, 0, 0);
    nops(2);
    add_fillers();
  endtask

  task automatic compare(input string name, input int idx, input logic [31:0] got,
                         input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH row %0d %s got %h expected %h", idx, name, got, exp);
    end
  endtask

  task automatic check_row(input row_t r, input int idx);
    compare("stall_fetch", idx, 32'(stall_fetch), 32'(r.sd));
    compare("stall_decode", idx, 32'(stall_decode), 32'(r.sd));
    compare("stall_execute", idx, 32'(stall_execute), 32'(r.se));
    compare("stall_mem", idx, 32'(stall_mem), 32'(r.se));
    compare("ex_to_ex", idx, 32'(ex_to_ex), 32'(r.e2e));
    compare("mem_to_ex", idx, 32'(mem_to_ex), 32'(r.m2e));
    compare("mem_to_mem", idx, 32'(mem_to_mem), 32'(r.m2m));
    compare("rf_wr_en", idx, 32'(rf_wr_en), 32'(r.rfe));
    compare("vrf_wr_en", idx, 32'(vrf_wr_en), 32'(r.vfe));
    // address and source only mean something on a write
    if (r.rfe) begin
      compare("rf_wr_addr", idx, 32'(rf_wr_addr), 32'(r.rfa));
      compare("rf_wr_src", idx, 32'(rf_wr_src), 32'(r.rfs));
    end
    if (r.vfe) begin
      compare("vrf_wr_addr", idx, 32'(vrf_wr_addr), 32'(r.vfa));
      compare("vrf_wr_src", idx, 32'(vrf_wr_src), 32'(WB_V));
    end
  endtask

  initial begin
    rst = 1'b1;
    instr = 32'd0;
    instr_valid = 1'b0;
    mem_stall_in = 1'b0;
    lfsr_state = 32'h4f4f_aaca;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (rows[i]) begin
      instr = rows[i].instr;
      instr_valid = rows[i].valid;
      mem_stall_in = rows[i].mstall;
      // sample one ns before the next rising edge when everything has settled
      #(PERIOD - 2);
      check_row(rows[i], i);
      @(posedge clk);
      #1;
    end
    $display("checks %0d, mismatches %0d", checks, mismatches);
    if (mismatches == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // the budget covers every table row, the reset cycles and some margin
  initial begin
    wait (table_ready);
    #((rows.size() + 20) * PERIOD);
    $display("timeout: the table did not finish within %0d cycles", rows.size() + 20);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog/hazard_detection_unit.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module hazard_detection_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  hazard_pkg::op_type_e     op_type,
  input  logic [`HAZ_REG_BITS:0]   vector_read_register_one,
  input  logic [`HAZ_REG_BITS:0]   vector_read_register_two,
  input  logic [`HAZ_REG_BITS:0]   scalar_read_register_one,
  input  logic [`HAZ_REG_BITS:0]   scalar_read_register_two,
  input  logic [`HAZ_REG_BITS-1:0] write_register,
  input  logic                     vector_wr_en,
  input  logic                     register_wr_en,
  input  logic                     mem_stall_in,
  output logic                     stall_fetch,
  output logic                     stall_decode,
  output logic                     stall_execute,
  output logic                     stall_mem,
  output logic [1:0]               ex_to_ex,
  output logic [1:0]               mem_to_ex,
  output logic [1:0]               mem_to_mem,
  output logic                     register_wb_sel,
  output logic                     vector_wb_sel,
  output logic                     buffer_register,
  output logic                     buffer_vector,
  output logic                     buffer_register_sel,
  output logic                     buffer_vector_sel,
  output logic [`HAZ_REG_BITS-1:0] scalar_wb_register,
  output logic                     scalar_wb_register_en,
  output logic                     scalar_wb_vector_en,
  output logic [`HAZ_REG_BITS-1:0] vector_wb_register
);
  localparam int VD = `HAZ_VECTOR_DEPTH;

  // scalar metadata where entry 0 is execute and entry 1 is mem
  hazard_pkg::op_type_e op_types_s [1:0];
  logic [`HAZ_REG_BITS-1:0] write_registers_s [1:0];
  logic vector_wr_ens_s [1:0];
  logic register_wr_ens_s [1:0];

  // vector metadata with one entry per vector stage
  logic [`HAZ_REG_BITS-1:0] write_registers_v [VD-1:0];
  logic vector_wr_ens_v [VD-1:0];
  logic register_wr_ens_v [VD-1:0];

  logic cur_vector;
  logic cur_scalar;
  logic cur_store;
  logic ex_is_load;
  logic [1:0] ex_hit;
  logic [1:0] mem_hit;
  logic vec_hit;
  logic load_use;
  logic partial_stall;
  logic full_stall;
  logic waw_stall;
  logic wb_conflict;
  logic newer;

  // bit j is set when the whole pipe was frozen j+1 cycles ago
  logic [VD-2:0] stall_hist;

  // seen_two[k] means vector entry k was accepted before the scalar mem entry
  logic [VD-1:0] seen_one;
  logic [VD-1:0] seen_two;

  // a live source that names a live destination
  function automatic logic src_match(logic [`HAZ_REG_BITS:0] src,
                                     logic [`HAZ_REG_BITS-1:0] dest, logic dest_en);
    return src[`HAZ_REG_BITS] & dest_en & (src[`HAZ_REG_BITS-1:0] == dest);
  endfunction

  assign cur_vector = (op_type == hazard_pkg::OPT_VEC) | (op_type == hazard_pkg::OPT_VMEM);
  assign cur_scalar = ~cur_vector;
  // a store is the only scalar memory operation without a destination
  assign cur_store = (op_type == hazard_pkg::OPT_MEM) & ~register_wr_en;
  assign ex_is_load = (op_types_s[0] == hazard_pkg::OPT_MEM);

  // a stalled decode slot enters both pipelines as a bubble
  hazard_fifo #(.DEPTH(VD)) i_vector_fifo (
    .clk             (clk),
    .rst             (rst),
    .en              (1'b1),
    .op_type         (op_type),
    .write_register  (write_register),
    .vector_wr_en    (vector_wr_en & cur_vector & ~stall_decode),
    .register_wr_en  (register_wr_en & cur_vector & ~stall_decode),
    .op_types        (),
    .write_registers (write_registers_v),
    .vector_wr_ens   (vector_wr_ens_v),
    .register_wr_ens (register_wr_ens_v)
  );

  // execute and mem hold their contents whenever the full stall is up
  hazard_fifo #(.DEPTH(2)) i_scalar_fifo (
    .clk             (clk),
    .rst             (rst),
    .en              (~full_stall),
    .op_type         (op_type),
    .write_register  (write_register),
    .vector_wr_en    (vector_wr_en & cur_scalar & ~stall_decode),
    .register_wr_en  (register_wr_en & cur_scalar & ~stall_decode),
    .op_types        (op_types_s),
    .write_registers (write_registers_s),
    .vector_wr_ens   (vector_wr_ens_s),
    .register_wr_ens (register_wr_ens_s)
  );

  // scalar sources against execute and mem
  assign ex_hit[0] = src_match(scalar_read_register_one, write_registers_s[0],
                               register_wr_ens_s[0]);
  assign ex_hit[1] = src_match(scalar_read_register_two, write_registers_s[0],
                               register_wr_ens_s[0]);
  assign mem_hit[0] = src_match(scalar_read_register_one, write_registers_s[1],
                                register_wr_ens_s[1]);
  assign mem_hit[1] = src_match(scalar_read_register_two, write_registers_s[1],
                                register_wr_ens_s[1]);

  // the vector pipeline has no bypass so any hit there stalls decode
  always_comb begin
    vec_hit = 1'b0;
    for (int k = 0; k < VD; k++) begin
      vec_hit = vec_hit
        | src_match(scalar_read_register_one, write_registers_v[k], register_wr_ens_v[k])
        | src_match(scalar_read_register_two, write_registers_v[k], register_wr_ens_v[k])
        | src_match(vector_read_register_one, write_registers_v[k], vector_wr_ens_v[k])
        | src_match(vector_read_register_two, write_registers_v[k], vector_wr_ens_v[k]);
    end
  end

  // execute results bypass unless they are still waiting on memory
  assign ex_to_ex = ex_hit & {2{cur_scalar & ~ex_is_load}};
  // a store can pick up load data late in its own mem stage
  assign mem_to_mem = ex_hit & {2{cur_store & ex_is_load}};
  // the younger execute result wins when both stages name the register
  assign mem_to_ex = mem_hit & ~ex_hit & {2{cur_scalar}};
  assign load_use = (|ex_hit) & ex_is_load & cur_scalar & ~cur_store;

  // vector instructions never take a bypass and wait on any producer
  assign partial_stall = vec_hit | load_use | (cur_vector & ((|ex_hit) | (|mem_hit)));

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stall_hist <= '0;
    end else begin
      stall_hist <= {stall_hist[VD-3:0], full_stall};
    end
  end

  // the mem entry was accepted on the second unfrozen cycle counting back
  // so a vector entry is older once two unfrozen cycles lie between them
  always_comb begin
    seen_one[0] = 1'b0;
    seen_two[0] = 1'b0;
    for (int k = 1; k < VD; k++) begin
      seen_one[k] = seen_one[k-1] | ~stall_hist[k-1];
      seen_two[k] = seen_two[k-1] | (seen_one[k-1] & ~stall_hist[k-1]);
    end
  end

  // the scalar result may not overtake an older vector write to the same register
  always_comb begin
    waw_stall = 1'b0;
    for (int k = 0; k < VD; k++) begin
      waw_stall = waw_stall | (seen_two[k] & register_wr_ens_v[k] & register_wr_ens_s[1]
                               & (write_registers_v[k] == write_registers_s[1]));
    end
  end

  assign newer = ~seen_two[VD-1];

  // a newer vector result steps aside for one cycle while the scalar one writes
  // this is only done when the scalar result is actually free to write now
  assign buffer_register = newer & register_wr_ens_v[VD-1] & register_wr_ens_s[1]
                           & ~mem_stall_in & ~waw_stall;
  assign buffer_vector = newer & vector_wr_ens_v[VD-1] & vector_wr_ens_s[1]
                         & ~mem_stall_in & ~waw_stall;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      buffer_register_sel <= 1'b0;
      buffer_vector_sel <= 1'b0;
    end else begin
      buffer_register_sel <= buffer_register;
      buffer_vector_sel <= buffer_vector;
    end
  end

  assign register_wb_sel = register_wr_ens_v[VD-1] & ~buffer_register;
  assign vector_wb_sel = vector_wr_ens_v[VD-1] & ~buffer_vector;

  // the scalar result waits while a direct or buffered vector write owns the port
  assign wb_conflict = ((register_wb_sel | buffer_register_sel) & register_wr_ens_s[1])
                     | ((vector_wb_sel | buffer_vector_sel) & vector_wr_ens_s[1]);

  assign full_stall = mem_stall_in | waw_stall | wb_conflict;

  assign stall_fetch = partial_stall | full_stall;
  assign stall_decode = partial_stall | full_stall;
  assign stall_execute = full_stall;
  assign stall_mem = full_stall;

  assign scalar_wb_register = write_registers_s[1];
  assign scalar_wb_register_en = register_wr_ens_s[1];
  assign scalar_wb_vector_en = vector_wr_ens_s[1];
  assign vector_wb_register = write_registers_v[VD-1];

endmodule

//--- verilog/hazard_fifo.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module hazard_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en,
  input  hazard_pkg::op_type_e     op_type,
  input  logic [`HAZ_REG_BITS-1:0] write_register,
  input  logic                     vector_wr_en,
  input  logic                     register_wr_en,
  output hazard_pkg::op_type_e     op_types [DEPTH-1:0],
  output logic [`HAZ_REG_BITS-1:0] write_registers [DEPTH-1:0],
  output logic                     vector_wr_ens [DEPTH-1:0],
  output logic                     register_wr_ens [DEPTH-1:0]
);

  // entry 0 holds the youngest instruction and entry DEPTH-1 the one about to write back
  // only the write enables decide whether an entry is live
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        vector_wr_ens[i] <= 1'b0;
        register_wr_ens[i] <= 1'b0;
      end
    end else if (en) begin
      vector_wr_ens[0] <= vector_wr_en;
      register_wr_ens[0] <= register_wr_en;
      for (int i = 1; i < DEPTH; i++) begin
        vector_wr_ens[i] <= vector_wr_ens[i-1];
        register_wr_ens[i] <= register_wr_ens[i-1];
      end
    end
  end

  // type and destination move down the chain next to their enables
  always_ff @(posedge clk) begin
    if (en) begin
      op_types[0] <= op_type;
      write_registers[0] <= write_register;
      for (int i = 1; i < DEPTH; i++) begin
        op_types[i] <= op_types[i-1];
        write_registers[i] <= write_registers[i-1];
      end
    end
  end

endmodule

//--- verilog/hazard_params.svh
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// number of stages in the vector pipeline
`define HAZ_VECTOR_DEPTH 9

// width of a register number in either register file
`define HAZ_REG_BITS 5

// field positions inside the 32-bit instruction word
// the opcode is four bits wide and sits at the very top of the word
`define HAZ_OPC_MSB 31
`define HAZ_RD_LSB 23
`define HAZ_RS1_LSB 18
`define HAZ_RS2_LSB 13

`endif

//--- verilog/hazard_pkg.sv
package hazard_pkg;

  // opcodes of the decoded instruction word
  // codes not listed here decode as a nop
  typedef enum logic [3:0] {
    OPC_NOP     = 4'd0,
    OPC_ALU     = 4'd1,
    OPC_LOAD    = 4'd2,
    OPC_STORE   = 4'd3,
    OPC_VALU    = 4'd4,
    OPC_VLOAD   = 4'd5,
    OPC_VREDUCE = 4'd6
  } opcode_e;

  // bit 1 selects the vector pipeline and bit 0 marks a memory operation
  typedef enum logic [1:0] {
    OPT_ALU  = 2'b00,
    OPT_MEM  = 2'b01,
    OPT_VEC  = 2'b10,
    OPT_VMEM = 2'b11
  } op_type_e;

  // source of a register file write in the writeback stage
  typedef enum logic [1:0] {
    WB_NONE     = 2'd0,
    WB_SCALAR   = 2'd1,
    WB_VECTOR   = 2'd2,
    WB_BUFFERED = 2'd3
  } wb_src_e;

endpackage

//--- verilog/hazard_top.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module hazard_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [31:0]              instr,
  input  logic                     instr_valid,
  input  logic                     mem_stall_in,
  output logic                     stall_fetch,
  output logic                     stall_decode,
  output logic                     stall_execute,
  output logic                     stall_mem,
  output logic [1:0]               ex_to_ex,
  output logic [1:0]               mem_to_ex,
  output logic [1:0]               mem_to_mem,
  output logic                     rf_wr_en,
  output logic [`HAZ_REG_BITS-1:0] rf_wr_addr,
  output hazard_pkg::wb_src_e      rf_wr_src,
  output logic                     vrf_wr_en,
  output logic [`HAZ_REG_BITS-1:0] vrf_wr_addr,
  output hazard_pkg::wb_src_e      vrf_wr_src
);
  hazard_pkg::op_type_e op_type;
  logic [`HAZ_REG_BITS:0] vector_read_register_one;
  logic [`HAZ_REG_BITS:0] vector_read_register_two;
  logic [`HAZ_REG_BITS:0] scalar_read_register_one;
  logic [`HAZ_REG_BITS:0] scalar_read_register_two;
  logic [`HAZ_REG_BITS-1:0] write_register;
  logic vector_wr_en;
  logic register_wr_en;

  // writeback selects and buffering between the detection unit and steering
  logic register_wb_sel;
  logic vector_wb_sel;
  logic buffer_register;
  logic buffer_vector;
  logic buffer_register_sel;
  logic buffer_vector_sel;
  logic [`HAZ_REG_BITS-1:0] scalar_wb_register;
  logic scalar_wb_register_en;
  logic scalar_wb_vector_en;
  logic [`HAZ_REG_BITS-1:0] vector_wb_register;

  instr_field_decoder i_decoder (
    .instr                    (instr),
    .instr_valid              (instr_valid),
    .op_type                  (op_type),
    .vector_read_register_one (vector_read_register_one),
    .vector_read_register_two (vector_read_register_two),
    .scalar_read_register_one (scalar_read_register_one),
    .scalar_read_register_two (scalar_read_register_two),
    .write_register           (write_register),
    .vector_wr_en             (vector_wr_en),
    .register_wr_en           (register_wr_en)
  );

  hazard_detection_unit i_detect (
    .clk                      (clk),
    .rst                      (rst),
    .op_type                  (op_type),
    .vector_read_register_one (vector_read_register_one),
    .vector_read_register_two (vector_read_register_two),
    .scalar_read_register_one (scalar_read_register_one),
    .scalar_read_register_two (scalar_read_register_two),
    .write_register           (write_register),
    .vector_wr_en             (vector_wr_en),
    .register_wr_en           (register_wr_en),
    .mem_stall_in             (mem_stall_in),
    .stall_fetch              (stall_fetch),
    .stall_decode             (stall_decode),
    .stall_execute            (stall_execute),
    .stall_mem                (stall_mem),
    .ex_to_ex                 (ex_to_ex),
    .mem_to_ex                (mem_to_ex),
    .mem_to_mem               (mem_to_mem),
    .register_wb_sel          (register_wb_sel),
    .vector_wb_sel            (vector_wb_sel),
    .buffer_register          (buffer_register),
    .buffer_vector            (buffer_vector),
    .buffer_register_sel      (buffer_register_sel),
    .buffer_vector_sel        (buffer_vector_sel),
    .scalar_wb_register       (scalar_wb_register),
    .scalar_wb_register_en    (scalar_wb_register_en),
    .scalar_wb_vector_en      (scalar_wb_vector_en),
    .vector_wb_register       (vector_wb_register)
  );

  writeback_steering i_steer (
    .clk                   (clk),
    .rst                   (rst),
    .stall_mem             (stall_mem),
    .register_wb_sel       (register_wb_sel),
    .vector_wb_sel         (vector_wb_sel),
    .buffer_register       (buffer_register),
    .buffer_vector         (buffer_vector),
    .buffer_register_sel   (buffer_register_sel),
    .buffer_vector_sel     (buffer_vector_sel),
    .scalar_wb_register    (scalar_wb_register),
    .scalar_wb_register_en (scalar_wb_register_en),
    .scalar_wb_vector_en   (scalar_wb_vector_en),
    .vector_wb_register    (vector_wb_register),
    .rf_wr_en              (rf_wr_en),
    .rf_wr_addr            (rf_wr_addr),
    .rf_wr_src             (rf_wr_src),
    .vrf_wr_en             (vrf_wr_en),
    .vrf_wr_addr           (vrf_wr_addr),
    .vrf_wr_src            (vrf_wr_src)
  );

endmodule

//--- verilog/instr_field_decoder.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module instr_field_decoder (
  input  logic                     instr_valid,
  input  logic [31:0]              instr,
  output hazard_pkg::op_type_e     op_type,
  output logic [`HAZ_REG_BITS:0]   vector_read_register_one,
  output logic [`HAZ_REG_BITS:0]   vector_read_register_two,
  output logic [`HAZ_REG_BITS:0]   scalar_read_register_one,
  output logic [`HAZ_REG_BITS:0]   scalar_read_register_two,
  output logic [`HAZ_REG_BITS-1:0] write_register,
  output logic                     vector_wr_en,
  output logic                     register_wr_en
);
  hazard_pkg::opcode_e opc;
  logic [`HAZ_REG_BITS-1:0] rs1;
  logic [`HAZ_REG_BITS-1:0] rs2;
  logic use_s1;
  logic use_s2;
  logic use_v1;
  logic use_v2;

  assign rs1 = instr[`HAZ_RS1_LSB +: `HAZ_REG_BITS];
  assign rs2 = instr[`HAZ_RS2_LSB +: `HAZ_REG_BITS];
  assign write_register = instr[`HAZ_RD_LSB +: `HAZ_REG_BITS];

  // bit 5 of every source field flags that the instruction really reads it
  assign scalar_read_register_one = {use_s1, rs1};
  assign scalar_read_register_two = {use_s2, rs2};
  assign vector_read_register_one = {use_v1, rs1};
  assign vector_read_register_two = {use_v2, rs2};

  always_comb begin
    // an empty slot behaves exactly like a nop
    if (instr_valid) begin
      opc = hazard_pkg::opcode_e'(instr[`HAZ_OPC_MSB -: 4]);
    end else begin
      opc = hazard_pkg::OPC_NOP;
    end
    op_type = hazard_pkg::OPT_ALU;
    use_s1 = 1'b0;
    use_s2 = 1'b0;
    use_v1 = 1'b0;
    use_v2 = 1'b0;
    vector_wr_en = 1'b0;
    register_wr_en = 1'b0;
    case (opc)
      hazard_pkg::OPC_ALU: begin
        use_s1 = 1'b1;
        use_s2 = 1'b1;
        register_wr_en = 1'b1;
      end
      hazard_pkg::OPC_LOAD: begin
        op_type = hazard_pkg::OPT_MEM;
        use_s1 = 1'b1;
        register_wr_en = 1'b1;
      end
      hazard_pkg::OPC_STORE: begin
        // rs1 carries the address and rs2 the data to be stored
        op_type = hazard_pkg::OPT_MEM;
        use_s1 = 1'b1;
        use_s2 = 1'b1;
      end
      hazard_pkg::OPC_VALU: begin
        op_type = hazard_pkg::OPT_VEC;
        use_v1 = 1'b1;
        use_v2 = 1'b1;
        vector_wr_en = 1'b1;
      end
      hazard_pkg::OPC_VLOAD: begin
        // the address of a vector load still comes from the scalar file
        op_type = hazard_pkg::OPT_VMEM;
        use_s1 = 1'b1;
        vector_wr_en = 1'b1;
      end
      hazard_pkg::OPC_VREDUCE: begin
        // a reduction runs down the vector pipeline but lands in the scalar file
        op_type = hazard_pkg::OPT_VEC;
        use_v1 = 1'b1;
        register_wr_en = 1'b1;
      end
      default: begin
        op_type = hazard_pkg::OPT_ALU;
      end
    endcase
  end

endmodule

//--- verilog/writeback_steering.sv
`timescale 1ns/1ps
`include "hazard_params.svh"

module writeback_steering (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall_mem,
  input  logic                     register_wb_sel,
  input  logic                     vector_wb_sel,
  input  logic                     buffer_register,
  input  logic                     buffer_vector,
  input  logic                     buffer_register_sel,
  input  logic                     buffer_vector_sel,
  input  logic [`HAZ_REG_BITS-1:0] scalar_wb_register,
  input  logic                     scalar_wb_register_en,
  input  logic                     scalar_wb_vector_en,
  input  logic [`HAZ_REG_BITS-1:0] vector_wb_register,
  output logic                     rf_wr_en,
  output logic [`HAZ_REG_BITS-1:0] rf_wr_addr,
  output hazard_pkg::wb_src_e      rf_wr_src,
  output logic                     vrf_wr_en,
  output logic [`HAZ_REG_BITS-1:0] vrf_wr_addr,
  output hazard_pkg::wb_src_e      vrf_wr_src
);
  // destination of the vector result that was set aside for one cycle
  logic [`HAZ_REG_BITS-1:0] held_register;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      held_register <= '0;
    end else if (buffer_register | buffer_vector) begin
      held_register <= vector_wb_register;
    end
  end

  // scalar file port priority is vector then buffered vector then scalar
  always_comb begin
    rf_wr_en = 1'b1;
    rf_wr_addr = scalar_wb_register;
    rf_wr_src = hazard_pkg::WB_SCALAR;
    if (register_wb_sel) begin
      rf_wr_addr = vector_wb_register;
      rf_wr_src = hazard_pkg::WB_VECTOR;
    end else if (buffer_register_sel) begin
      rf_wr_addr = held_register;
      rf_wr_src = hazard_pkg::WB_BUFFERED;
    end else if (~scalar_wb_register_en | stall_mem) begin
      rf_wr_en = 1'b0;
      rf_wr_src = hazard_pkg::WB_NONE;
    end
  end

  // vector file port follows the same order
  always_comb begin
    vrf_wr_en = 1'b1;
    vrf_wr_addr = scalar_wb_register;
    vrf_wr_src = hazard_pkg::WB_SCALAR;
    if (vector_wb_sel) begin
      vrf_wr_addr = vector_wb_register;
      vrf_wr_src = hazard_pkg::WB_VECTOR;
    end else if (buffer_vector_sel) begin
      vrf_wr_addr = held_register;
      vrf_wr_src = hazard_pkg::WB_BUFFERED;
    end else if (~scalar_wb_vector_en | stall_mem) begin
      vrf_wr_en = 1'b0;
      vrf_wr_src = hazard_pkg::WB_NONE;
    end
  end

endmodule
